//--- verilog.f
+incdir+bench
logic/zx_bus_pkg.sv
logic/zx_mem_pkg.sv
logic/paging_regs.sv
logic/addr_mapper.sv
logic/sdram_port.sv
logic/zx_mem_top.sv
bench/zx_mem_properties.sv
bench/tb_zx_mem.sv

//--- Bender.yml
package:
  name: zx_mem

sources:
  - logic/zx_bus_pkg.sv
  - logic/zx_mem_pkg.sv
  - logic/paging_regs.sv
  - logic/addr_mapper.sv
  - logic/sdram_port.sv
  - logic/zx_mem_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/zx_mem_properties.sv
      - bench/tb_zx_mem.sv

//--- bench/zx_mem_model.svh
// Reference paging model for the memory host testbench
// Mirrors the paging registers and maps CPU addresses onto SDRAM

`ifndef ZX_MEM_MODEL_SVH
`define ZX_MEM_MODEL_SVH

logic [2:0] m_mode;
logic [7:0] m_page_reg;
logic [7:0] m_plus3;
logic [7:0] m_p1024_reg;
logic [2:0] m_page_128k;

function automatic void model_reset(input logic [2:0] mode);
	m_mode      = mode;
	m_page_reg  = 8'h00;
	m_plus3     = 8'h00;
	m_p1024_reg = 8'h00;
	m_page_128k = 3'd0;
endfunction

function automatic logic model_locked();
	if (m_mode == zx_bus_pkg::MODE_48)
		return 1'b1;
	if (m_mode == zx_bus_pkg::MODE_P1024)
		return m_page_reg[5] & m_p1024_reg[2]; // Lock needs EFF7 bit 2 too
	return m_page_reg[5];
endfunction

function automatic void model_io_write(input logic [15:0] a, input logic [7:0] d);
	logic plus3;
	logic lock;
	plus3 = (m_mode == zx_bus_pkg::MODE_PLUS3);
	lock  = model_locked();
	if (!a[15] && !a[1] && (a[14] || !plus3) && !lock) begin
		m_page_reg = d;
		if (m_mode == zx_bus_pkg::MODE_P1024 && !m_p1024_reg[2])
			m_page_128k = {d[5], d[7], d[6]};
	end
	if (a[15:12] == 4'h1 && !a[1] && plus3 && !lock)
		m_plus3 = d;
	if (m_mode == zx_bus_pkg::MODE_PROFI && a == 16'hDFFD)
		m_page_128k = d[2:0];
	if (m_mode == zx_bus_pkg::MODE_P1024 && a[15:13] == 3'b111 && !a[12] && !a[3])
		m_p1024_reg = d;
endfunction

// Banks for quarters 3..0, quarter 0 in the low bits
function automatic logic [11:0] model_spec_layout(input logic [1:0] cfg);
	case (cfg)
		2'd0:    return {3'd3, 3'd2, 3'd1, 3'd0};
		2'd1:    return {3'd7, 3'd6, 3'd5, 3'd4};
		2'd2:    return {3'd3, 3'd6, 3'd5, 3'd4};
		default: return {3'd3, 3'd6, 3'd7, 3'd4};
	endcase
endfunction

function automatic int model_addr(input logic [15:0] a);
	int          q;
	int          zx48;
	int          rom;
	logic [11:0] layout;
	q    = a[15:14];
	zx48 = (m_mode == zx_bus_pkg::MODE_48);
	if (m_plus3[0]) begin
		layout = model_spec_layout(m_plus3[2:1]);
		return layout[q*3 +: 3] * 16384 + a[13:0];
	end
	if (q == 0) begin
		if (m_mode == zx_bus_pkg::MODE_PLUS3)
			rom = 8 + 2 * m_plus3[2] + m_page_reg[4];
		else
			rom = 8 * zx48 + 6 + (zx48 | m_page_reg[4]);
		return 5 * (1 << 18) + rom * 16384 + a[13:0]; // ROM region above RAM
	end
	if (q == 1)
		return 5 * 16384 + a[13:0];
	if (q == 2)
		return 2 * 16384 + a[13:0];
	return (m_page_128k * 8 + m_page_reg[2:0]) * 16384 + a[13:0];
endfunction

function automatic logic model_write_ok(input logic [15:0] a);
	return m_plus3[0] || (a[15:14] != 2'd0);
endfunction

`endif

//--- bench/tb_zx_mem.sv
// Testbench for the Spectrum memory host
// Random CPU bus master and an SDRAM responder with random ack latency,
// checked against a reference paging model

`timescale 1ns/1ps

module tb_zx_mem;

	localparam int AW           = zx_mem_pkg::SDRAM_AW;
	localparam int MAX_LAT      = 6;
	localparam int RESET_CYCLES = 8;
	localparam int BUS_CYCLES   = 380; // Summed over all tests
	localparam int CYCLE_LIMIT  = BUS_CYCLES * (4 + MAX_LAT) + 6 * (RESET_CYCLES + 1) + 500;

	logic                   clk_sys;
	logic                   reset;
	zx_bus_pkg::mem_mode_e  mem_mode;
	zx_bus_pkg::zx_bus_t    bus;
	zx_mem_pkg::sdram_cmd_t sdram_cmd;
	zx_mem_pkg::sdram_cmd_t cmd_seen;   // As taken by the responder
	logic                   sdram_ack;
	logic [15:0]            sdram_dout;
	logic [7:0]             cpu_din;
	logic                   ready;
	logic [7:0]             sdram_mem [int unsigned];

	integer seed       = 36821;
	int     cycle_cnt  = 0;
	int     toggle_cnt = 0;
	int     lat_cnt    = 0;
	int     err_cnt    = 0;
	int     test_err   = 0;
	int     test_cnt   = 0;
	int     fail_cnt   = 0;

	`include "zx_mem_model.svh"

	zx_mem_top i_zx_mem_top (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mem_mode_i   (mem_mode),
		.bus_i        (bus),
		.sdram_cmd_o  (sdram_cmd),
		.sdram_ack_i  (sdram_ack),
		.sdram_dout_i (sdram_dout),
		.cpu_din_o    (cpu_din),
		.ready_o      (ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("Run timed out after %0d cycles, a bus cycle never finished", cycle_cnt);
		$display("TEST FAIL");
		$finish;
	end

	// ======================================================================
	// SDRAM responder
	// ======================================================================

	function automatic logic [7:0] sdram_byte(input logic [AW-1:0] a);
		if (sdram_mem.exists(a))
			return sdram_mem[a];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {a[24], 7'h35}; // Unwritten fill
	endfunction

	always @(posedge clk_sys) begin
		if (reset) begin
			sdram_ack <= 1'b0;
			lat_cnt = 0;
		end else if (lat_cnt != 0) begin
			lat_cnt = lat_cnt - 1;
			if (lat_cnt == 0) begin
				if (cmd_seen.we)
					sdram_mem[cmd_seen.addr] = cmd_seen.din;
				sdram_dout <= {sdram_byte({cmd_seen.addr[AW-1:1], 1'b1}),
				               sdram_byte({cmd_seen.addr[AW-1:1], 1'b0})};
				sdram_ack  <= cmd_seen.req;
			end
		end else if (sdram_cmd.req != sdram_ack) begin
			cmd_seen   = sdram_cmd;
			toggle_cnt = toggle_cnt + 1;
			lat_cnt    = 1 + {$random(seed)} % MAX_LAT;
		end
	end

	// ======================================================================
	// CPU bus master and checks
	// ======================================================================

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic apply_reset(input zx_bus_pkg::mem_mode_e mode);
		@(posedge clk_sys);
		reset    <= 1'b1;
		mem_mode <= mode;
		bus      <= '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		model_reset(mode);
	endtask

	task automatic mem_cycle(input logic [15:0] addr, input logic wr, input logic [7:0] data,
	                         output logic [7:0] rdata);
		int          toggles;
		int          exp_addr;
		logic        exp_req;
		exp_addr = model_addr(addr);
		exp_req  = !wr || model_write_ok(addr);
		toggles  = toggle_cnt;
		@(posedge clk_sys);
		bus <= {addr, data, 1'b1, 1'b0, ~wr, wr, 1'b0};
		repeat (2) @(posedge clk_sys); // Req toggles within two cycles
		while (!ready)
			@(posedge clk_sys);
		rdata = cpu_din;
		check_val("req toggles", toggle_cnt - toggles, exp_req);
		check_val("sdram_ack_i", sdram_ack, sdram_cmd.req);
		if (exp_req) begin
			check_val("sdram_cmd_o.addr", sdram_cmd.addr, exp_addr);
			check_val("sdram_cmd_o.we", sdram_cmd.we, wr);
			if (wr)
				check_val("sdram_cmd_o.din", sdram_cmd.din, data);
			else
				check_val("cpu_din_o", cpu_din, sdram_byte(exp_addr));
		end
		bus <= '0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		int toggles;
		toggles = toggle_cnt;
		@(posedge clk_sys);
		bus <= {addr, data, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
		repeat (2) @(posedge clk_sys);
		bus <= '0;
		model_io_write(addr, data);
		check_val("req toggles", toggle_cnt - toggles, 0);
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (test_err != 0)
			fail_cnt++;
		$display("Test %0d %s finished with %0d errors", test_cnt, name, test_err);
		test_err = 0;
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  rdata;
		logic [15:0] a;
		reset      = 1'b1;
		mem_mode   = zx_bus_pkg::MODE_128;
		bus        = '0;
		sdram_ack  = 1'b0;
		sdram_dout = 16'h0000;

		for (int m = 0; m < 5; m++) begin
			apply_reset(zx_bus_pkg::mem_mode_e'(m));
			for (int q = 0; q < 4; q++) begin
				r = next_rand();
				mem_cycle({q[1:0], r[13:0]}, 1'b0, 8'h00, rdata);
			end
		end
		end_test("default map per mode");

		apply_reset(zx_bus_pkg::MODE_128);
		repeat (20) begin
			r = next_rand();
			io_write({1'b0, r[14:2], 1'b0, r[0]}, {r[23:22], 1'b0, r[20:16]}); // Partial decode
			mem_cycle({2'b11, r[29:16]}, 1'b0, 8'h00, rdata);
			mem_cycle({2'b00, r[13:0]}, 1'b0, 8'h00, rdata);
		end
		io_write(16'h7FFD, 8'h20 | r[7:0]);
		repeat (10) begin
			r = next_rand();
			io_write(16'h7FFD, r[7:0]);
			mem_cycle({2'b11, r[29:16]}, 1'b0, 8'h00, rdata);
			mem_cycle({2'b00, r[13:0]}, 1'b0, 8'h00, rdata);
		end
		end_test("128K paging and lock");

		apply_reset(zx_bus_pkg::MODE_PLUS3);
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			io_write(16'h7FFD, {r[7:6], 1'b0, i[1], 1'b0, r[2:0]});
			io_write(16'h1FFD, {r[15:11], i[0], r[9], 1'b0});
			mem_cycle({2'b00, r[29:16]}, 1'b0, 8'h00, rdata);
		end
		for (int c = 0; c < 4; c++) begin
			io_write(16'h1FFD, {5'b00000, c[1:0], 1'b1});
			for (int q = 0; q < 4; q++) begin
				r = next_rand();
				mem_cycle({q[1:0], r[13:0]}, 1'b0, 8'h00, rdata);
			end
			mem_cycle({2'b00, r[29:16]}, 1'b1, r[7:0], rdata); // Quarter 0 is RAM here
		end
		end_test("+3 ROM select and special layouts");

		apply_reset(zx_bus_pkg::MODE_P1024);
		repeat (16) begin
			r = next_rand();
			io_write(16'hEFF7, r[31:24] & 8'hFB);
			io_write(16'h7FFD, r[7:0]);
			mem_cycle({2'b11, r[21:8]}, 1'b0, 8'h00, rdata);
		end
		apply_reset(zx_bus_pkg::MODE_PROFI);
		repeat (16) begin
			r = next_rand();
			io_write(zx_bus_pkg::PORT_DFFD, r[31:24]);
			io_write(16'h7FFD, r[7:0] & 8'hDF);
			mem_cycle({2'b11, r[21:8]}, 1'b0, 8'h00, rdata);
		end
		end_test("P1024 and Profi banks");

		apply_reset(zx_bus_pkg::MODE_128);
		repeat (30) begin
			r = next_rand();
			a = {(r[31:30] == 2'b00) ? 2'b01 : r[31:30], r[13:0]};
			mem_cycle(a, 1'b1, r[21:14], rdata);
			mem_cycle(a, 1'b0, 8'h00, rdata);
			check_val("cpu_din_o", rdata, r[21:14]);
		end
		repeat (4) begin
			r = next_rand();
			mem_cycle({2'b00, r[13:0]}, 1'b1, r[21:14], rdata);
			mem_cycle({2'b00, r[13:0]}, 1'b0, 8'h00, rdata);
		end
		end_test("write, read back and ROM protect");

		apply_reset(zx_bus_pkg::MODE_48);
		repeat (60) begin
			r = next_rand();
			mem_cycle(r[15:0], r[16], r[24:17], rdata);
		end
		end_test("random cycles under random latency");

		err_cnt += i_zx_mem_top.i_sdram_port.i_zx_mem_properties.assert_fails;
		$display("Summary: %0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- bench/zx_mem_properties.sv
// SDRAM handshake checks for the memory host
// Toggle req/ack rules bound into the SDRAM requester

`timescale 1ns/1ps

module zx_mem_properties (
	input logic                   clk_sys,
	input logic                   reset,
	input zx_mem_pkg::sdram_cmd_t cmd_i,
	input logic                   ack_i,
	input logic                   ready_i
);

	int assert_fails = 0;

	// New request only once the last one is done
	req_toggle_idle: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(cmd_i.req) |-> $past(ack_i == cmd_i.req))
		else begin
			$error("req toggled while a request was outstanding");
			assert_fails++;
		end

	// Ready drops before req toggles and stays low once it has
	ready_low_busy: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(cmd_i.req) |-> ($past(!ready_i) && !ready_i))
		else begin
			$error("ready high around a new request");
			assert_fails++;
		end

	idle_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (cmd_i.req == ack_i))
		else begin
			$error("req and ack differ after reset");
			assert_fails++;
		end

	we_stable_busy: assert property (@(posedge clk_sys) disable iff (reset)
		((cmd_i.req != ack_i) && $past(cmd_i.req != ack_i)) |-> $stable(cmd_i.we))
		else begin
			$error("we changed while a request was outstanding");
			assert_fails++;
		end

endmodule

bind sdram_port zx_mem_properties i_zx_mem_properties (
	.clk_sys (clk_sys),
	.reset   (reset),
	.cmd_i   (sdram_cmd_o),
	.ack_i   (sdram_ack_i),
	.ready_i (ready_o)
);

//--- logic/zx_mem_top.sv
// Spectrum memory host top level
// CPU bus cycles in, paged SDRAM requests out

`timescale 1ns/1ps

module zx_mem_top #(
	parameter int SDRAM_AW = zx_mem_pkg::SDRAM_AW
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_bus_pkg::mem_mode_e  mem_mode_i,
	input  zx_bus_pkg::zx_bus_t    bus_i,
	output zx_mem_pkg::sdram_cmd_t sdram_cmd_o,
	input  logic                   sdram_ack_i,
	input  logic [15:0]            sdram_dout_i,
	output logic [7:0]             cpu_din_o,
	output logic                   ready_o
);

	zx_mem_pkg::paging_t                 paging;
	logic [zx_mem_pkg::SDRAM_AW-1:0]     mem_addr;
	logic                                mem_rd;
	logic                                mem_we;
	logic [7:0]                          mem_din;

	paging_regs i_paging_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mem_mode_i (mem_mode_i),
		.bus_i      (bus_i),
		.paging_o   (paging)
	);

	addr_mapper i_addr_mapper (
		.paging_i   (paging),
		.bus_i      (bus_i),
		.mem_addr_o (mem_addr),
		.mem_rd_o   (mem_rd),
		.mem_we_o   (mem_we),
		.mem_din_o  (mem_din)
	);

	// Mapped addresses stay below 2MB, so a narrower SDRAM keeps the low bits
	sdram_port #(
		.ADDR_W (SDRAM_AW)
	) i_sdram_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mem_addr_i   (mem_addr[SDRAM_AW-1:0]),
		.mem_rd_i     (mem_rd),
		.mem_we_i     (mem_we),
		.mem_din_i    (mem_din),
		.sdram_cmd_o  (sdram_cmd_o),
		.sdram_ack_i  (sdram_ack_i),
		.sdram_dout_i (sdram_dout_i),
		.cpu_din_o    (cpu_din_o),
		.ready_o      (ready_o)
	);

endmodule

//--- logic/sdram_port.sv
// Single SDRAM requester with toggle req/ack handshake
// Edge detects CPU reads and writes, latches the command and returns
// the addressed byte with a ready flag

`timescale 1ns/1ps

module sdram_port #(
	parameter int ADDR_W = zx_mem_pkg::SDRAM_AW
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [ADDR_W-1:0]      mem_addr_i,
	input  logic                   mem_rd_i,
	input  logic                   mem_we_i,
	input  logic [7:0]             mem_din_i,
	output zx_mem_pkg::sdram_cmd_t sdram_cmd_o,
	input  logic                   sdram_ack_i,
	input  logic [15:0]            sdram_dout_i,
	output logic [7:0]             cpu_din_o,
	output logic                   ready_o
);

	logic              rd_q1;
	logic              rd_q2;
	logic              we_q1;
	logic              new_req;
	logic              req_q;
	logic              we_q;
	logic [ADDR_W-1:0] addr_q;
	logic [7:0]        din_q;

	// ======================================================================
	// Request detect
	// ======================================================================

	// Reads wait one more cycle for the address decode to settle
	assign new_req = (rd_q1 & ~rd_q2) | (mem_we_i & ~we_q1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q1 <= 1'b0;
			rd_q2 <= 1'b0;
			we_q1 <= 1'b0;
			req_q <= 1'b0;
			we_q  <= 1'b0;
		end else begin
			rd_q1 <= mem_rd_i;
			rd_q2 <= rd_q1;
			we_q1 <= mem_we_i;
			if (new_req) begin
				req_q <= ~req_q; // Controller acks by matching this
				we_q  <= mem_we_i;
			end
		end
	end

	// Command payload
	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			addr_q <= mem_addr_i;
			din_q  <= mem_din_i;
		end
	end

	// ======================================================================
	// Command and response
	// ======================================================================

	always_comb begin
		sdram_cmd_o              = '0;
		sdram_cmd_o.req          = req_q;
		sdram_cmd_o.we           = we_q;
		sdram_cmd_o.addr[ADDR_W-1:0] = addr_q;
		sdram_cmd_o.din          = din_q;
	end

	// Even byte on the low lane
	assign cpu_din_o = addr_q[0] ? sdram_dout_i[15:8] : sdram_dout_i[7:0];

	assign ready_o = (sdram_ack_i == req_q) & ~new_req;

endmodule

//--- logic/addr_mapper.sv
// CPU address to SDRAM address mapper
// Selects the ROM page, maps the four 16K quarters onto SDRAM banks
// and blocks writes into ROM

`timescale 1ns/1ps

module addr_mapper (
	input  zx_mem_pkg::paging_t                 paging_i,
	input  zx_bus_pkg::zx_bus_t                 bus_i,
	output logic [zx_mem_pkg::SDRAM_AW-1:0]     mem_addr_o,
	output logic                                mem_rd_o,
	output logic                                mem_we_o,
	output logic [7:0]                          mem_din_o
);

	localparam int BW = zx_mem_pkg::BANK_W;

	logic [1:0]    quarter;
	logic [BW-1:0] offset;
	logic          special;
	logic [3:0]    rom_page;
	logic [2:0]    spec_bank;
	logic [5:0]    ram_bank;

	assign quarter = bus_i.addr[15:14];
	assign offset  = bus_i.addr[BW-1:0];
	assign special = paging_i.plus3.spec.special;

	// +3 has four ROMs, the older models two
	assign rom_page = paging_i.is_plus3 ?
		{2'b10, paging_i.plus3.norm.rom_hi, paging_i.page_reg[4]} :
		{paging_i.zx48, 2'b11, paging_i.zx48 | paging_i.page_reg[4]};

	// +3 all-RAM layouts
	always_comb begin
		case (paging_i.plus3.spec.cfg)
			2'd0: spec_bank = {1'b0, quarter};
			2'd1: spec_bank = {1'b1, quarter};
			2'd2: spec_bank = (quarter == 2'd3) ? 3'd3 : {1'b1, quarter};
			default: begin
				case (quarter)
					2'd0:    spec_bank = 3'd4;
					2'd1:    spec_bank = 3'd7;
					2'd2:    spec_bank = 3'd6;
					default: spec_bank = 3'd3;
				endcase
			end
		endcase
	end

	always_comb begin
		case (quarter)
			2'd1:    ram_bank = 6'd5;
			2'd2:    ram_bank = 6'd2;
			default: ram_bank = {paging_i.page_128k, paging_i.page_reg[2:0]};
		endcase
	end

	always_comb begin
		mem_addr_o = '0;
		if (special) begin
			mem_addr_o[BW+2:0] = {spec_bank, offset};
		end else if (quarter == 2'd0) begin
			mem_addr_o[BW+6:0] = {zx_mem_pkg::ROM_BANK_PREFIX, rom_page, offset};
		end else begin
			mem_addr_o[BW+5:0] = {ram_bank, offset};
		end
	end

	assign mem_rd_o  = bus_i.mreq & bus_i.rd;
	assign mem_we_o  = bus_i.mreq & bus_i.wr & (special | (quarter != 2'd0)); // ROM is read only
	assign mem_din_o = bus_i.dout;

endmodule

//--- logic/paging_regs.sv
// Spectrum paging registers
// Decodes I/O writes to 7FFD, 1FFD, DFFD and EFF7 and holds the paging
// state for all memory models

`timescale 1ns/1ps

module paging_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_bus_pkg::mem_mode_e mem_mode_i,
	input  zx_bus_pkg::zx_bus_t   bus_i,
	output zx_mem_pkg::paging_t   paging_o
);

	zx_mem_pkg::paging_t regs;

	logic io_wr;
	logic io_wr_q;
	logic io_wr_rise;
	logic locked;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_dffd;
	logic sel_eff7;

	// ======================================================================
	// Port decode
	// ======================================================================

	assign io_wr      = bus_i.iorq & bus_i.wr & ~bus_i.m1; // No interrupt ack
	assign io_wr_rise = io_wr & ~io_wr_q;

	// Pentagon 1024 only honours the lock bit when EFF7 bit 2 is set
	assign locked = regs.zx48 |
	                (~regs.p1024 & regs.page_reg[5]) |
	                (regs.p1024 & regs.p1024_reg[2] & regs.page_reg[5]);

	// Partial decode, +3 also needs A14 to tell 7FFD from 1FFD
	assign sel_7ffd = ~bus_i.addr[15] & ~bus_i.addr[1] &
	                  (bus_i.addr[14] | ~regs.is_plus3) & ~locked;

	assign sel_1ffd = (bus_i.addr[15:12] == 4'b0001) & ~bus_i.addr[1] &
	                  regs.is_plus3 & ~locked;

	assign sel_dffd = regs.pf1024 & (bus_i.addr == zx_bus_pkg::PORT_DFFD);

	assign sel_eff7 = regs.p1024 & (bus_i.addr[15:13] == 3'b111) &
	                  ~bus_i.addr[12] & ~bus_i.addr[3];

	// ======================================================================
	// Registers
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q          <= 1'b0;
			regs.page_reg    <= 8'h00;
			regs.plus3       <= 8'h00;
			regs.p1024_reg   <= 8'h00;
			regs.page_128k   <= 3'd0;
			// Model is only picked up while in reset
			regs.zx48     <= (mem_mode_i == zx_bus_pkg::MODE_48);
			regs.p1024    <= (mem_mode_i == zx_bus_pkg::MODE_P1024);
			regs.pf1024   <= (mem_mode_i == zx_bus_pkg::MODE_PROFI);
			regs.is_plus3 <= (mem_mode_i == zx_bus_pkg::MODE_PLUS3);
		end else begin
			io_wr_q <= io_wr;

			if (io_wr_rise) begin
				if (sel_7ffd) begin
					regs.page_reg <= bus_i.dout;
					// Pentagon extra bank bits ride on D7..D5
					if (regs.p1024 & ~regs.p1024_reg[2]) begin
						regs.page_128k <= {bus_i.dout[5], bus_i.dout[7:6]};
					end
				end else if (sel_1ffd) begin
					regs.plus3 <= bus_i.dout;
				end

				if (sel_dffd) begin
					regs.page_128k <= bus_i.dout[2:0]; // Profi bank bits
				end

				if (sel_eff7) begin
					regs.p1024_reg <= bus_i.dout;
				end
			end
		end
	end

	assign paging_o = regs;

endmodule

//--- logic/zx_mem_pkg.sv
// Memory side definitions for the Spectrum memory host
// SDRAM widths, region bases, paging state and the SDRAM command word

package zx_mem_pkg;

	localparam int SDRAM_AW = 25; // Byte address into SDRAM
	localparam int BANK_W   = 14; // Offset inside one 16K bank

	// ROM pages live in their own region above the RAM banks
	localparam logic [2:0] ROM_BANK_PREFIX = 3'b101;

	// ======================================================================
	// +3 paging register (port 1FFD)
	// ======================================================================

	// Bit 0 picks which view is meaningful
	typedef union packed {
		struct packed {
			logic [3:0] rsvd_hi;
			logic       motor;     // Disk motor
			logic       rom_hi;    // High bit of ROM page
			logic       rsvd_lo;
			logic       special;
		} norm;
		struct packed {
			logic [4:0] rsvd_hi;
			logic [1:0] cfg;       // All-RAM layout select
			logic       special;
		} spec;
	} plus3_page_u;

	// ======================================================================
	// Paging state seen by the address mapper
	// ======================================================================

	typedef struct packed {
		logic [7:0]  page_reg;   // 7FFD
		plus3_page_u plus3;      // 1FFD
		logic [7:0]  p1024_reg;  // EFF7
		logic [2:0]  page_128k;  // Extra RAM bank bits above 128K
		logic        zx48;
		logic        p1024;
		logic        pf1024;
		logic        is_plus3;
	} paging_t;

	// Toggle req/ack command towards the SDRAM controller
	typedef struct packed {
		logic                req;
		logic                we;
		logic [SDRAM_AW-1:0] addr;
		logic [7:0]          din;
	} sdram_cmd_t;

endpackage

//--- logic/zx_bus_pkg.sv
// CPU bus side definitions for the Spectrum memory host
// One bus sample, the machine memory models and the I/O port constants

package zx_bus_pkg;

	// ======================================================================
	// CPU bus sample
	// ======================================================================

	// All strobes are active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout; // Data driven by the CPU
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} zx_bus_t;

	// ======================================================================
	// Machine memory models
	// ======================================================================

	typedef enum logic [2:0] {
		MODE_128   = 3'd0, // Standard 128K
		MODE_P1024 = 3'd1, // Pentagon 1024K
		MODE_PROFI = 3'd2, // Profi 1024K
		MODE_48    = 3'd3,
		MODE_PLUS3 = 3'd4  // +2A/+3
	} mem_mode_e;

	// Profi extended paging port, fully decoded
	localparam logic [15:0] PORT_DFFD = 16'hDFFD;

endpackage
